// ==== cache_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl (
  input  wire                            clk_i,
  input  wire                            rst_i,
  input  wire                            s_cyc_i,
  input  wire                            s_stb_i,
  input  wire                            s_we_i,
  output logic                           s_ack_o,
  input  wire wb_cache_pkg::cache_tag_t   req_tag_i,
  input  wire wb_cache_pkg::cache_index_t req_index_i,
  input  wire                            hit_i,
  input  wire wb_cache_pkg::dirty_t       dirty_i,
  input  wire wb_cache_pkg::cache_tag_t   victim_tag_i,
  input  wire                            m_ack_i,
  output logic                           m_cyc_o,
  output logic                           m_stb_o,
  output logic                           m_we_o,
  output wb_cache_pkg::wb_adr_t          m_adr_o,
  output wb_cache_pkg::cache_index_t     ram_adr_o,
  output logic                           ram_we_o,
  output wb_cache_pkg::buf_op_t          buf_op_o,
  output wb_cache_pkg::word_off_t        buf_word_o
);

  import wb_cache_pkg::*;

  ctrl_state_t  state_q;
  ctrl_state_t  state_d;
  word_off_t    word_cnt_q;
  word_off_t    word_cnt_d;
  cache_index_t init_idx_q;
  cache_index_t init_idx_d;
  logic         gap_q; // Beat acked last cycle

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ST_INIT;
      word_cnt_q <= '0;
      init_idx_q <= '0;
      gap_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      word_cnt_q <= word_cnt_d;
      init_idx_q <= init_idx_d;
      gap_q      <= m_cyc_o && m_ack_i;
    end
  end

  always_comb begin
    state_d    = state_q;
    word_cnt_d = word_cnt_q;
    init_idx_d = init_idx_q;
    s_ack_o    = 1'b0;
    m_cyc_o    = 1'b0;
    m_we_o     = 1'b0;
    m_adr_o    = {req_tag_i, req_index_i, word_cnt_q};
    ram_we_o   = 1'b0;
    buf_op_o   = BUF_HOLD;

    case (state_q)
      ST_INIT: begin
        ram_we_o   = 1'b1; // Buffer still holds the zero row
        init_idx_d = init_idx_q + 1'b1;
        if (&init_idx_q) begin
          state_d = ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (s_cyc_i && s_stb_i) begin
          state_d = ST_READ;
        end
      end
      ST_READ: begin
        state_d = ST_LOAD; // Row memory read in flight
      end
      ST_LOAD: begin
        buf_op_o = BUF_LOAD;
        state_d  = ST_CHECK;
      end
      ST_CHECK: begin
        if (hit_i) begin
          if (s_we_i) begin
            buf_op_o = BUF_MERGE;
          end
          state_d = ST_DONE;
        end else if (|dirty_i) begin
          state_d = ST_FLUSH; // Dirty implies a valid victim
        end else begin
          state_d = ST_FILL;
        end
      end
      ST_DONE: begin
        s_ack_o  = 1'b1;
        ram_we_o = s_we_i; // Store merged row
        state_d  = ST_IDLE;
      end
      ST_FLUSH: begin
        m_adr_o = {victim_tag_i, req_index_i, word_cnt_q};
        if (dirty_i[word_cnt_q]) begin
          m_cyc_o = 1'b1;
          m_we_o  = 1'b1;
          if (m_ack_i) begin
            buf_op_o = BUF_CLEAN_WORD; // Bit clears, next cycle moves on
          end
        end else begin
          word_cnt_d = word_cnt_q + 1'b1;
          if (&word_cnt_q) begin
            state_d = ST_FILL;
          end
        end
      end
      ST_FILL: begin
        m_cyc_o = !gap_q;
        if (m_cyc_o && m_ack_i) begin
          buf_op_o   = BUF_FILL_WORD;
          word_cnt_d = word_cnt_q + 1'b1;
          if (&word_cnt_q) begin
            state_d = ST_FILL_WRITE;
          end
        end
      end
      ST_FILL_WRITE: begin
        ram_we_o = 1'b1;
        state_d  = ST_CHECK; // Retry lookup, now a hit
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign m_stb_o    = m_cyc_o;
  assign buf_word_o = word_cnt_q;
  assign ram_adr_o  = (state_q == ST_INIT) ? init_idx_q : req_index_i;

  // Outside master must hold its request until ack
  a_ack_in_cycle : assert property (
    @(posedge clk_i) disable iff (rst_i)
    s_ack_o |-> (s_cyc_i && s_stb_i)
  );

  // Open beat never abandoned
  a_beat_held : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (m_cyc_o && !m_ack_i) |=> m_cyc_o
  );

  a_store_hit : assert property (
    @(posedge clk_i) disable iff (rst_i)
    ram_we_o |-> ((state_q == ST_INIT) || hit_i)
  );

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "wb_cache_defs.svh"

module line_buffer (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire wb_cache_pkg::buf_op_t   op_i,
  input  wire wb_cache_pkg::word_off_t word_i,
  input  wire wb_cache_pkg::cache_tag_t req_tag_i,
  input  wire wb_cache_pkg::word_off_t req_off_i,
  input  wire wb_cache_pkg::wb_dat_t   s_dat_i,
  input  wire wb_cache_pkg::wb_sel_t   s_sel_i,
  input  wire wb_cache_pkg::wb_dat_t   m_dat_i,
  input  wire wb_cache_pkg::cache_row_t row_q_i,
  output wb_cache_pkg::cache_row_t     row_d_o,
  output logic                         hit_o,
  output wb_cache_pkg::dirty_t         dirty_o,
  output wb_cache_pkg::cache_tag_t     victim_tag_o,
  output wb_cache_pkg::wb_dat_t        s_dat_o,
  output wb_cache_pkg::wb_dat_t        m_dat_o
);

  import wb_cache_pkg::*;

  cache_row_t buf_row;
  cache_row_t row_nxt;
  logic       row_valid;

  always_comb begin
    row_nxt = buf_row;
    case (op_i)
      BUF_LOAD: begin
        row_nxt = row_q_i; // Whole row, so later merges keep the other words
      end
      BUF_MERGE: begin
        for (int b = 0; b < `WB_SEL_W; b++) begin
          if (s_sel_i[b]) begin
            row_nxt[req_off_i * `WB_DAT_W + b * 8 +: 8] = s_dat_i[b * 8 +: 8];
          end
        end
        row_nxt[`ROW_DIRTY_LSB + req_off_i] = 1'b1;
      end
      BUF_FILL_WORD: begin
        row_nxt[word_i * `WB_DAT_W +: `WB_DAT_W] = m_dat_i;
        row_nxt[`ROW_DIRTY_LSB + word_i] = 1'b0;
        row_nxt[`ROW_TAG_LSB +: `TAG_W] = req_tag_i; // New owner of the line
        row_nxt[`ROW_VALID_BIT] = 1'b1;
      end
      BUF_CLEAN_WORD: begin
        row_nxt[`ROW_DIRTY_LSB + word_i] = 1'b0; // Word written back
      end
      default: begin
        row_nxt = buf_row;
      end
    endcase
  end

  // Zero row doubles as the invalid row for the init sweep
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      buf_row <= '0;
    end else begin
      buf_row <= row_nxt;
    end
  end

  assign row_valid    = buf_row[`ROW_VALID_BIT];
  assign victim_tag_o = buf_row[`ROW_TAG_LSB +: `TAG_W];
  assign dirty_o      = buf_row[`ROW_DIRTY_LSB +: `LINE_WORDS];
  assign hit_o        = row_valid && (victim_tag_o == req_tag_i);
  assign row_d_o      = buf_row;

  assign s_dat_o = buf_row[req_off_i * `WB_DAT_W +: `WB_DAT_W];
  assign m_dat_o = buf_row[word_i * `WB_DAT_W +: `WB_DAT_W]; // Writeback data

  // Controller only merges into a line it has just confirmed
  a_merge_on_hit : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (op_i == BUF_MERGE) |-> hit_o
  );

endmodule

`default_nettype wire

// ==== line_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "wb_cache_defs.svh"

module line_ram (
  input  wire                        clk_i,
  input  wire wb_cache_pkg::cache_index_t adr_i,
  input  wire                        we_i,
  input  wire wb_cache_pkg::cache_row_t   row_d_i,
  output wb_cache_pkg::cache_row_t        row_q_o
);

  import wb_cache_pkg::*;

  localparam int DEPTH = 1 << `INDEX_W;

  cache_row_t mem [DEPTH];

  // Read-first single port, one-cycle latency
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[adr_i] <= row_d_i;
    end
    row_q_o <= mem[adr_i];
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wb_cache.f --top-module tb_wb_cache \
  -Mdir obj_dir -o sim_wb_cache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_wb_cache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb_mem_model.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_mem_model (
  input  wire         clk_i,
  input  wire         cyc_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire  [24:0] adr_i,
  input  wire  [31:0] dat_i,
  input  wire  [1:0]  max_delay_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  localparam int WORDS     = 1 << 16;
  localparam int LOG_DEPTH = 4096;

  logic [31:0] mem [WORDS]; // Window on the low 16 address bits
  logic [24:0] log_adr [LOG_DEPTH]; // One entry per acked beat
  logic        log_we [LOG_DEPTH];
  logic [31:0] log_dat [LOG_DEPTH];
  int          log_cnt;
  logic [31:0] rng;
  int          wait_cnt;
  int          delay;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  initial begin
    ack_o    = 1'b0;
    dat_o    = '0;
    log_cnt  = 0;
    wait_cnt = 0;
    delay    = 1;
    rng      = 32'hce51;
    for (int i = 0; i < WORDS; i++) begin
      rng    = xorshift32(rng);
      mem[i] = rng;
    end
    forever begin
      @(negedge clk_i);
      if (ack_o) begin
        ack_o    = 1'b0; // Single-cycle ack
        wait_cnt = 0;
      end else if (cyc_i && stb_i) begin
        if (wait_cnt == 0) begin
          rng   = xorshift32(rng);
          delay = (max_delay_i == 2'd0) ? 1 : 1 + int'(rng[7:0] % {6'd0, max_delay_i});
        end
        wait_cnt++;
        if (wait_cnt >= delay) begin
          ack_o = 1'b1;
          if (we_i) begin
            mem[adr_i[15:0]] = dat_i;
          end else begin
            dat_o = mem[adr_i[15:0]];
          end
          if (log_cnt < LOG_DEPTH) begin
            log_adr[log_cnt] = adr_i;
            log_we[log_cnt]  = we_i;
            log_dat[log_cnt] = we_i ? dat_i : dat_o;
            log_cnt++;
          end
        end
      end else begin
        wait_cnt = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_wb_cache.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "wb_cache_defs.svh"

module tb_wb_cache;

  localparam int CLK_PERIOD  = 8;
  localparam int MEM_WORDS   = 1 << 16;
  localparam int ACK_LIMIT   = 400; // Long enough for the init sweep
  localparam int ACCESSES    = 240;
  localparam int MISS_CYCLES = 60; // Eight beats at three wait cycles plus gaps
  localparam int WATCHDOG_NS = (300 + ACCESSES * MISS_CYCLES) * CLK_PERIOD;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 s_cyc;
  logic                 s_stb;
  logic                 s_we;
  logic [`WB_ADR_W-1:0] s_adr;
  logic [`WB_SEL_W-1:0] s_sel;
  logic [`WB_DAT_W-1:0] s_dat_w;
  wire  [`WB_DAT_W-1:0] s_dat_r;
  wire                  s_ack;
  wire                  m_cyc;
  wire                  m_stb;
  wire                  m_we;
  wire  [`WB_ADR_W-1:0] m_adr;
  wire  [`WB_SEL_W-1:0] m_sel;
  wire  [`WB_DAT_W-1:0] m_dat_w;
  wire  [`WB_DAT_W-1:0] m_dat_r;
  wire                  m_ack;
  logic [1:0]           max_delay;
  logic [31:0]          ref_mem [MEM_WORDS];
  logic [31:0]          rng;
  int                   checks;
  int                   errors;

  wb_cache_top u_dut (
    .clk_i (clk), .rst_i (rst),
    .s_cyc_i (s_cyc), .s_stb_i (s_stb), .s_we_i (s_we), .s_adr_i (s_adr),
    .s_sel_i (s_sel), .s_dat_i (s_dat_w), .s_dat_o (s_dat_r), .s_ack_o (s_ack),
    .m_cyc_o (m_cyc), .m_stb_o (m_stb), .m_we_o (m_we), .m_adr_o (m_adr),
    .m_sel_o (m_sel), .m_dat_o (m_dat_w), .m_dat_i (m_dat_r), .m_ack_i (m_ack)
  );

  tb_mem_model u_mem (
    .clk_i (clk), .cyc_i (m_cyc), .stb_i (m_stb), .we_i (m_we), .adr_i (m_adr),
    .dat_i (m_dat_w), .max_delay_i (max_delay), .dat_o (m_dat_r), .ack_o (m_ack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [24:0] cache_addr(input int tag, input int index, input int off);
    return {tag[14:0], index[7:0], off[1:0]};
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[b*8 +: 8] = dat[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_int(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic bus_access(input logic we, input logic [24:0] adr, input logic [3:0] sel,
                            input logic [31:0] wdat, output logic [31:0] rdat,
                            output int cycles, output logic busy);
    cycles = 0;
    busy   = 1'b0;
    rdat   = '0;
    s_cyc  = 1'b1;
    s_stb  = 1'b1;
    s_we   = we;
    s_adr  = adr;
    s_sel  = sel;
    s_dat_w = wdat;
    do begin
      @(negedge clk);
      cycles++;
      if (m_cyc) begin
        busy = 1'b1;
        check_int("m_sel_o", int'(m_sel), 15);
      end
      check_int("m_stb_o", int'(m_stb), int'(m_cyc));
    end while (!s_ack && cycles < ACK_LIMIT);
    checks++;
    assert (s_ack) else begin
      errors++;
      $display("No acknowledge for address %h within %0d cycles", adr, ACK_LIMIT);
    end
    rdat = s_dat_r;
    @(negedge clk);
    s_cyc = 1'b0;
    s_stb = 1'b0;
    s_we  = 1'b0;
  endtask

  task automatic read_expect(input logic [24:0] adr, output int cycles, output logic busy);
    logic [31:0] got;
    bus_access(1'b0, adr, 4'hf, 32'h0, got, cycles, busy);
    check_word("s_dat_o", got, ref_mem[adr[15:0]]);
  endtask

  task automatic write_word(input logic [24:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output int cycles);
    logic [31:0] unused_dat;
    logic        busy;
    bus_access(1'b1, adr, sel, dat, unused_dat, cycles, busy);
    ref_mem[adr[15:0]] = merge_lanes(ref_mem[adr[15:0]], dat, sel);
  endtask

  task automatic check_beat(input int pos, input logic we, input logic [24:0] adr);
    check_int("beat m_we_o", int'(u_mem.log_we[pos]), int'(we));
    check_word("beat m_adr_o", {7'd0, u_mem.log_adr[pos]}, {7'd0, adr});
  endtask

  task automatic test_init_miss();
    int   base;
    int   cyc;
    logic busy;
    base = u_mem.log_cnt;
    read_expect(cache_addr(3, 5, 2), cyc, busy); // Issued during the sweep
    check_int("refill beat count", u_mem.log_cnt - base, 4);
    for (int w = 0; w < 4; w++) check_beat(base + w, 1'b0, cache_addr(3, 5, w));
  endtask

  task automatic test_read_hit();
    int   base;
    int   cyc;
    logic busy;
    base = u_mem.log_cnt;
    read_expect(cache_addr(3, 5, 0), cyc, busy);
    check_int("read hit latency", cyc, 4);
    check_int("m_cyc_o during hit", int'(busy), 0);
    check_int("beats on read hit", u_mem.log_cnt - base, 0);
  endtask

  task automatic test_byte_lanes();
    int   base;
    int   cyc;
    logic busy;
    base = u_mem.log_cnt;
    write_word(cache_addr(3, 5, 1), 4'b0101, next_rand(), cyc);
    check_int("write hit latency", cyc, 4);
    write_word(cache_addr(3, 5, 2), 4'b1000, next_rand(), cyc);
    write_word(cache_addr(3, 5, 1), 4'b0010, next_rand(), cyc);
    for (int w = 0; w < 4; w++) read_expect(cache_addr(3, 5, w), cyc, busy);
    check_int("beats on write hits", u_mem.log_cnt - base, 0);
  endtask

  task automatic test_writeback();
    int   base;
    int   cyc;
    logic busy;
    read_expect(cache_addr(7, 9, 0), cyc, busy);
    write_word(cache_addr(7, 9, 0), 4'hf, next_rand(), cyc);
    write_word(cache_addr(7, 9, 3), 4'b1100, next_rand(), cyc);
    base = u_mem.log_cnt;
    read_expect(cache_addr(20, 9, 1), cyc, busy); // Same index, other tag
    check_int("writeback beat count", u_mem.log_cnt - base, 6);
    check_beat(base, 1'b1, cache_addr(7, 9, 0));
    check_beat(base + 1, 1'b1, cache_addr(7, 9, 3));
    check_word("m_dat_o word 0", u_mem.log_dat[base], ref_mem[cache_addr(7, 9, 0) & 16'hffff]);
    check_word("m_dat_o word 3", u_mem.log_dat[base + 1], ref_mem[cache_addr(7, 9, 3) & 16'hffff]);
    for (int w = 0; w < 4; w++) check_beat(base + 2 + w, 1'b0, cache_addr(20, 9, w));
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    logic [24:0] adr;
    int          cyc;
    logic        busy;
    max_delay = 2'd3;
    for (int i = 0; i < 200; i++) begin
      r   = next_rand();
      adr = cache_addr(30 + int'(r[3:2]), 12 + int'(r[1:0]), int'(r[5:4]));
      if (r[6]) write_word(adr, r[10:7], next_rand(), cyc);
      else read_expect(adr, cyc, busy);
    end
    read_expect(cache_addr(50, 5, 0), cyc, busy); // Push out every line used so far
    read_expect(cache_addr(50, 9, 0), cyc, busy);
    for (int idx = 12; idx < 16; idx++) read_expect(cache_addr(50, idx, 0), cyc, busy);
    for (int a = 0; a < MEM_WORDS; a++) begin
      checks++;
      assert (u_mem.mem[a] === ref_mem[a]) else begin
        errors++;
        $display("[ERROR] %0t mem[%h]: got %h expected %h", $time, a[15:0], u_mem.mem[a],
                 ref_mem[a]);
      end
    end
  endtask

  initial begin
    rst       = 1'b1;
    s_cyc     = 1'b0;
    s_stb     = 1'b0;
    s_we      = 1'b0;
    s_adr     = '0;
    s_sel     = '0;
    s_dat_w   = '0;
    max_delay = 2'd1;
    checks    = 0;
    errors    = 0;
    rng       = 32'hce51;
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = next_rand(); // Same pattern as the model
    repeat (4) @(negedge clk);
    rst = 1'b0;
    test_init_miss();
    test_read_hit();
    test_byte_lanes();
    test_writeback();
    test_random_mix();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not complete within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_cache.f ====
+incdir+.
wb_cache_pkg.sv
line_ram.sv
line_buffer.sv
cache_ctrl.sv
wb_cache_top.sv
tb_mem_model.sv
tb_wb_cache.sv

// ==== wb_cache_defs.svh ====
`ifndef WB_CACHE_DEFS_SVH
`define WB_CACHE_DEFS_SVH

// Wishbone port widths
`define WB_ADR_W 25
`define WB_DAT_W 32
`define WB_SEL_W 4

// Address split: tag | index | word offset
`define TAG_W 15
`define INDEX_W 8
`define OFFSET_W 2
`define LINE_WORDS 4

// Row layout, low to high: data words, tag, dirty bits, valid
`define ROW_W 148
`define ROW_TAG_LSB 128
`define ROW_DIRTY_LSB 143
`define ROW_VALID_BIT 147

`endif

// ==== wb_cache_pkg.sv ====
`default_nettype none

`include "wb_cache_defs.svh"

package wb_cache_pkg;

  typedef logic [`WB_ADR_W-1:0] wb_adr_t;
  typedef logic [`WB_DAT_W-1:0] wb_dat_t;
  typedef logic [`WB_SEL_W-1:0] wb_sel_t;

  typedef logic [`TAG_W-1:0] cache_tag_t;
  typedef logic [`INDEX_W-1:0] cache_index_t;
  typedef logic [`OFFSET_W-1:0] word_off_t;

  typedef logic [`ROW_W-1:0] cache_row_t;
  typedef logic [`LINE_WORDS-1:0] dirty_t;

  typedef enum logic [3:0] {
    ST_INIT, ST_IDLE, ST_READ, ST_LOAD, ST_CHECK,
    ST_DONE, ST_FLUSH, ST_FILL, ST_FILL_WRITE
  } ctrl_state_t;

  typedef enum logic [2:0] {
    BUF_HOLD, BUF_LOAD, BUF_MERGE, BUF_FILL_WORD, BUF_CLEAN_WORD
  } buf_op_t;

endpackage

`default_nettype wire

// ==== wb_cache_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module wb_cache_top (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          s_cyc_i,
  input  wire                          s_stb_i,
  input  wire                          s_we_i,
  input  wire wb_cache_pkg::wb_adr_t   s_adr_i,
  input  wire wb_cache_pkg::wb_sel_t   s_sel_i,
  input  wire wb_cache_pkg::wb_dat_t   s_dat_i,
  output wire wb_cache_pkg::wb_dat_t   s_dat_o,
  output wire                          s_ack_o,
  output wire                          m_cyc_o,
  output wire                          m_stb_o,
  output wire                          m_we_o,
  output wire wb_cache_pkg::wb_adr_t   m_adr_o,
  output wire wb_cache_pkg::wb_sel_t   m_sel_o,
  output wire wb_cache_pkg::wb_dat_t   m_dat_o,
  input  wire wb_cache_pkg::wb_dat_t   m_dat_i,
  input  wire                          m_ack_i
);

  import wb_cache_pkg::*;

  cache_tag_t   req_tag;
  cache_index_t req_index;
  word_off_t    req_off;
  logic         hit;
  dirty_t       dirty;
  cache_tag_t   victim_tag;
  cache_index_t ram_adr;
  logic         ram_we;
  buf_op_t      buf_op;
  word_off_t    buf_word;
  cache_row_t   row_d;
  cache_row_t   row_q;

  assign {req_tag, req_index, req_off} = s_adr_i;
  assign m_sel_o = '1; // Writeback always full words

  cache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_cyc_i      (s_cyc_i),
    .s_stb_i      (s_stb_i),
    .s_we_i       (s_we_i),
    .s_ack_o      (s_ack_o),
    .req_tag_i    (req_tag),
    .req_index_i  (req_index),
    .hit_i        (hit),
    .dirty_i      (dirty),
    .victim_tag_i (victim_tag),
    .m_ack_i      (m_ack_i),
    .m_cyc_o      (m_cyc_o),
    .m_stb_o      (m_stb_o),
    .m_we_o       (m_we_o),
    .m_adr_o      (m_adr_o),
    .ram_adr_o    (ram_adr),
    .ram_we_o     (ram_we),
    .buf_op_o     (buf_op),
    .buf_word_o   (buf_word)
  );

  line_buffer u_buf (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .op_i         (buf_op),
    .word_i       (buf_word),
    .req_tag_i    (req_tag),
    .req_off_i    (req_off),
    .s_dat_i      (s_dat_i),
    .s_sel_i      (s_sel_i),
    .m_dat_i      (m_dat_i),
    .row_q_i      (row_q),
    .row_d_o      (row_d),
    .hit_o        (hit),
    .dirty_o      (dirty),
    .victim_tag_o (victim_tag),
    .s_dat_o      (s_dat_o),
    .m_dat_o      (m_dat_o)
  );

  line_ram u_ram (
    .clk_i   (clk_i),
    .adr_i   (ram_adr),
    .we_i    (ram_we),
    .row_d_i (row_d),
    .row_q_o (row_q)
  );

endmodule

`default_nettype wire
